//--- Makefile
# Verilator build and run for the ATS21 testbench

VERILATOR ?= verilator
TOP       ?= tbAts21
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- alarmBank.sv
/*
  Alarm and timer bank
  holds the alarm registers, compares each one against its
  clock after a step, and stretches a hit into a 2-cycle
  pulse on data
*/
`default_nettype none

module alarmBank import ats21Pkg::*; #(
  parameter int numClocks = defNumClocks,
  parameter int numAlarms = defNumAlarms
) (
  input  wire logic                 clk_1x,
  input  wire logic                 reset,
  input  wire alarmCmdT             alarmCmdA,
  input  wire alarmCmdT             alarmCmdB,
  input  wire countT                count [numClocks],
  input  wire logic [numClocks-1:0] stepped,
  output logic [numAlarms-1:0]      data
);

  //////////////////////////////
  // alarm state
  //////////////////////////////
  logic [numAlarms-1:0] almEn;
  logic [numAlarms-1:0] almRep;    // repeat, stays armed after a hit
  clockIdxT             almClk [numAlarms];
  countT                almVal [numAlarms];
  logic [numAlarms-1:0] match;     // comb compare
  logic [numAlarms-1:0] hitQ;      // match delayed one edge
  logic [1:0]           holdCnt [numAlarms];
  logic [numAlarms-1:0] cmdHit;
  alarmCmdT             cmdSel [numAlarms];

  always_comb begin
    for (int i = 0; i < numAlarms; i++) begin
      cmdHit[i] = 1'b0;
      cmdSel[i] = alarmCmdA;
      if (alarmCmdA.valid && int'(alarmCmdA.alarm) == i) begin
        cmdHit[i] = 1'b1;
      end else if (alarmCmdB.valid && int'(alarmCmdB.alarm) == i) begin
        cmdHit[i] = 1'b1;
        cmdSel[i] = alarmCmdB;
      end
    end
  end

  // only look right after the bound clock advanced
  always_comb begin
    for (int i = 0; i < numAlarms; i++) begin
      match[i] = almEn[i] && stepped[almClk[i]] && (count[almClk[i]] == almVal[i]);
    end
  end

  //////////////////////////////
  // control and hold
  //////////////////////////////
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      almEn  <= '0;
      almRep <= '0;
      hitQ   <= '0;
      for (int i = 0; i < numAlarms; i++) begin
        holdCnt[i] <= '0;
      end
    end else begin
      hitQ <= match;
      for (int i = 0; i < numAlarms; i++) begin
        if (cmdHit[i]) begin
          case (cmdSel[i].kind)
            akSetAlarm: begin
              almEn[i]  <= 1'b1;
              almRep[i] <= cmdSel[i].flag;
            end
            akSetTimer: begin
              almEn[i]  <= 1'b1;
              almRep[i] <= 1'b0;      // timers are one-shot
            end
            default: almEn[i] <= cmdSel[i].flag;
          endcase
        end else if (match[i] && !almRep[i]) begin
          almEn[i] <= 1'b0;           // one-shot disarms itself
        end
        if (hitQ[i]) begin
          holdCnt[i] <= 2'd2;         // restarts if already high
        end else if (holdCnt[i] != 2'd0) begin
          holdCnt[i] <= holdCnt[i] - 2'd1;
        end
      end
    end
  end

  // value and clock binding
  always_ff @(posedge clk_1x) begin
    for (int i = 0; i < numAlarms; i++) begin
      if (cmdHit[i] && cmdSel[i].kind == akSetAlarm) begin
        almClk[i] <= cmdSel[i].clock;
        almVal[i] <= cmdSel[i].value;
      end else if (cmdHit[i] && cmdSel[i].kind == akSetTimer) begin
        almClk[i] <= cmdSel[i].clock;
        almVal[i] <= count[cmdSel[i].clock] + cmdSel[i].value;  // mod 2^16
      end
    end
  end

  for (genvar i = 0; i < numAlarms; i++) begin : gData
    assign data[i] = (holdCnt[i] != 2'd0);

    // third high cycle needs a fresh hit
    aHoldLen: assert property (@(posedge clk_1x) disable iff (reset)
      (data[i] && $past(data[i]) && $past(data[i], 2))
        |-> ($past(hitQ[i]) || $past(hitQ[i], 2)));
  end

endmodule

`default_nettype wire

//--- ats21Pkg.sv
/*
  ATS21 shared definitions
  widths, opcodes, the 32-bit instruction layout and the
  command structs passed from stage to stage
*/
`default_nettype none

package ats21Pkg;

  //////////////////////////////
  // widths and defaults
  //////////////////////////////
  typedef logic [15:0] countT;     // software clock or alarm value
  typedef logic [3:0]  clockIdxT;  // clock number
  typedef logic [4:0]  alarmIdxT;  // alarm number
  typedef logic [1:0]  rateT;      // 0 every cycle, 1 every 2nd, 2 every 4th, 3 stopped

  localparam int defNumClocks = 16;
  localparam int defNumAlarms = 24;

  //////////////////////////////
  // encodings
  //////////////////////////////
  typedef enum logic [2:0] {
    opNop      = 3'b000,
    opSetClock = 3'b001,
    opEnClock  = 3'b010,
    opMode     = 3'b011,  // no longer served, answered with Nack
    opSetAlarm = 3'b101,
    opSetTimer = 3'b110,
    opEnAlarm  = 3'b111
  } opcodeT;              // 3'b100 left undefined

  typedef enum logic {
    Nack = 1'b0,
    Ack  = 1'b1
  } statusT;

  typedef enum logic [1:0] {
    akSetAlarm,           // absolute alarm
    akSetTimer,           // countdown, value relative to clock
    akEnable              // enable/disable only
  } alarmKindT;

  // instruction, upper half sent first
  typedef struct packed {
    opcodeT   opcode;     // [31:29]
    alarmIdxT target;     // [28:24] alarm no, clock no sits in [28:25]
    logic     flag;       // [23] repeat or enable
    rateT     rate;       // [22:21]
    logic     spare;      // [20]
    clockIdxT clock;      // [19:16] clock an alarm is bound to
    countT    value;      // [15:0] count, alarm time or interval
  } instrT;

  typedef struct packed {
    logic  valid;         // one-cycle pulse
    instrT instr;
  } cmdWordT;

  typedef struct packed {
    logic     valid;
    logic     isSet;      // set clock, else enable/disable
    clockIdxT clock;
    rateT     rate;
    countT    value;
    logic     enable;
  } clockCmdT;

  typedef struct packed {
    logic      valid;
    alarmKindT kind;
    alarmIdxT  alarm;
    clockIdxT  clock;
    logic      flag;      // repeat for set alarm, enable for akEnable
    countT     value;     // alarm time or interval
  } alarmCmdT;

endpackage

`default_nettype wire

//--- ats21Top.sv
/*
  ATS21 timer and alarm block
  two instruction assemblers feed a shared decoder, which
  drives the clock bank and the alarm bank
*/
`default_nettype none

module ats21Top import ats21Pkg::*; #(
  parameter int numClocks = defNumClocks,
  parameter int numAlarms = defNumAlarms
) (
  input  wire logic            clk_1x,
  input  wire logic            reset,
  input  wire logic            req,
  input  wire logic [15:0]     ctrlA,
  input  wire logic [15:0]     ctrlB,
  output logic [1:0]           stat,     // bit 1 client B, bit 0 client A
  output logic [numAlarms-1:0] data
);

  cmdWordT              wordA, wordB;
  clockCmdT             clockCmdA, clockCmdB;
  alarmCmdT             alarmCmdA, alarmCmdB;
  countT                count [numClocks];
  logic [numClocks-1:0] stepped;

  //////////////////////////////
  // front end, one per client
  //////////////////////////////
  wordAssembler asmA (
    .clk_1x (clk_1x),
    .reset  (reset),
    .req    (req),
    .half   (ctrlA),
    .word   (wordA)
  );

  wordAssembler asmB (
    .clk_1x (clk_1x),
    .reset  (reset),
    .req    (req),
    .half   (ctrlB),
    .word   (wordB)
  );

  commandDecoder #(
    .numClocks (numClocks),
    .numAlarms (numAlarms)
  ) cmdDec (
    .clk_1x    (clk_1x),
    .reset     (reset),
    .wordA     (wordA),
    .wordB     (wordB),
    .stat      (stat),
    .clockCmdA (clockCmdA),
    .clockCmdB (clockCmdB),
    .alarmCmdA (alarmCmdA),
    .alarmCmdB (alarmCmdB)
  );

  //////////////////////////////
  // back end
  //////////////////////////////
  clockBank #(
    .numClocks (numClocks)
  ) clkBank (
    .clk_1x    (clk_1x),
    .reset     (reset),
    .clockCmdA (clockCmdA),
    .clockCmdB (clockCmdB),
    .count     (count),
    .stepped   (stepped)
  );

  alarmBank #(
    .numClocks (numClocks),
    .numAlarms (numAlarms)
  ) almBank (
    .clk_1x    (clk_1x),
    .reset     (reset),
    .alarmCmdA (alarmCmdA),
    .alarmCmdB (alarmCmdB),
    .count     (count),
    .stepped   (stepped),
    .data      (data)
  );

endmodule

`default_nettype wire

//--- clockBank.sv
/*
  Software clock bank
  free-running divider for the 1x, 2x and 4x rate ticks,
  plus one 16-bit counter per clock with set and enable
*/
`default_nettype none

module clockBank import ats21Pkg::*; #(
  parameter int numClocks = defNumClocks
) (
  input  wire logic            clk_1x,
  input  wire logic            reset,
  input  wire clockCmdT        clockCmdA,
  input  wire clockCmdT        clockCmdB,
  output countT                count [numClocks],
  output logic [numClocks-1:0] stepped
);

  logic [1:0]           divCnt;     // phase fixed by reset
  logic [3:0]           rateTick;   // one bit per rateT code
  logic [numClocks-1:0] clkEn;
  rateT                 clkRate [numClocks];
  logic [numClocks-1:0] cmdHit;
  clockCmdT             cmdSel [numClocks];

  // rate 3 never ticks
  assign rateTick = {1'b0, divCnt == 2'b11, divCnt[0], 1'b1};

  // route A or B to each clock, decoder keeps them apart
  always_comb begin
    for (int c = 0; c < numClocks; c++) begin
      cmdHit[c] = 1'b0;
      cmdSel[c] = clockCmdA;
      if (clockCmdA.valid && int'(clockCmdA.clock) == c) begin
        cmdHit[c] = 1'b1;
      end else if (clockCmdB.valid && int'(clockCmdB.clock) == c) begin
        cmdHit[c] = 1'b1;
        cmdSel[c] = clockCmdB;
      end
    end
  end

  //////////////////////////////
  // counters
  //////////////////////////////
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      divCnt  <= '0;
      clkEn   <= '0;
      stepped <= '0;
      for (int c = 0; c < numClocks; c++) begin
        count[c]   <= '0;
        clkRate[c] <= '0;
      end
    end else begin
      divCnt <= divCnt + 2'd1;
      for (int c = 0; c < numClocks; c++) begin
        stepped[c] <= 1'b0;
        if (cmdHit[c]) begin                          // command beats tick
          clkEn[c] <= cmdSel[c].isSet ? 1'b1 : cmdSel[c].enable;
          if (cmdSel[c].isSet) begin
            count[c]   <= cmdSel[c].value;
            clkRate[c] <= cmdSel[c].rate;
          end
        end else if (clkEn[c] && rateTick[clkRate[c]]) begin
          count[c]   <= count[c] + 16'd1;             // wraps at 2^16
          stepped[c] <= 1'b1;                         // alarms compare next cycle
        end
      end
    end
  end

  // stopped clocks only move on a set
  for (genvar c = 0; c < numClocks; c++) begin : gStopChk
    aStopped: assert property (@(posedge clk_1x) disable iff (reset)
      (clkRate[c] == 2'd3 && !(cmdHit[c] && cmdSel[c].isSet)) |=> $stable(count[c]));
  end

endmodule

`default_nettype wire

//--- commandDecoder.sv
/*
  Command decoder
  classifies the words of both clients, refuses a pair that
  hits the same clock or alarm, and issues registered clock
  and alarm commands together with the Ack/Nack status
*/
`default_nettype none

module commandDecoder import ats21Pkg::*; #(
  parameter int numClocks = defNumClocks,
  parameter int numAlarms = defNumAlarms
) (
  input  wire logic    clk_1x,
  input  wire logic    reset,
  input  wire cmdWordT wordA,
  input  wire cmdWordT wordB,
  output logic [1:0]   stat,
  output clockCmdT     clockCmdA,
  output clockCmdT     clockCmdB,
  output alarmCmdT     alarmCmdA,
  output alarmCmdT     alarmCmdB
);

  //////////////////////////////
  // classification
  //////////////////////////////
  function automatic logic isClockOp(cmdWordT w);
    logic opOk;
    opOk = (w.instr.opcode == opSetClock) || (w.instr.opcode == opEnClock);
    return w.valid && opOk && (int'(w.instr.target[4:1]) < numClocks);
  endfunction

  function automatic logic isAlarmOp(cmdWordT w);
    logic isSet;
    logic clkOk;
    isSet = (w.instr.opcode == opSetAlarm) || (w.instr.opcode == opSetTimer);
    clkOk = !isSet || (int'(w.instr.clock) < numClocks);  // enable ignores clock field
    return w.valid && (isSet || w.instr.opcode == opEnAlarm) && clkOk
           && (int'(w.instr.target) < numAlarms);
  endfunction

  function automatic clockCmdT toClockCmd(cmdWordT w, logic issue);
    clockCmdT c;
    c.valid  = issue;
    c.isSet  = (w.instr.opcode == opSetClock);
    c.clock  = w.instr.target[4:1];   // clock no is top of target
    c.rate   = w.instr.rate;
    c.value  = w.instr.value;
    c.enable = w.instr.flag;
    return c;
  endfunction

  function automatic alarmCmdT toAlarmCmd(cmdWordT w, logic issue);
    alarmCmdT c;
    c.valid = issue;
    case (w.instr.opcode)
      opSetAlarm: c.kind = akSetAlarm;
      opSetTimer: c.kind = akSetTimer;
      default:    c.kind = akEnable;
    endcase
    c.alarm = w.instr.target;
    c.clock = w.instr.clock;
    c.flag  = w.instr.flag;
    c.value = w.instr.value;
    return c;
  endfunction

  logic   clkA, clkB, almA, almB;
  logic   conflict;       // both clients on one resource
  statusT statA, statB;

  assign clkA = isClockOp(wordA);
  assign clkB = isClockOp(wordB);
  assign almA = isAlarmOp(wordA);
  assign almB = isAlarmOp(wordB);

  assign conflict = (clkA && clkB && (wordA.instr.target[4:1] == wordB.instr.target[4:1]))
                 || (almA && almB && (wordA.instr.target == wordB.instr.target));

  //////////////////////////////
  // registered issue and status
  //////////////////////////////
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      statA     <= Nack;
      statB     <= Nack;
      clockCmdA <= '0;
      clockCmdB <= '0;
      alarmCmdA <= '0;
      alarmCmdB <= '0;
    end else begin
      statA     <= ((clkA || almA) && !conflict) ? Ack : Nack;  // idle cycles read Nack
      statB     <= ((clkB || almB) && !conflict) ? Ack : Nack;
      clockCmdA <= toClockCmd(wordA, clkA && !conflict);
      clockCmdB <= toClockCmd(wordB, clkB && !conflict);
      alarmCmdA <= toAlarmCmd(wordA, almA && !conflict);
      alarmCmdB <= toAlarmCmd(wordB, almB && !conflict);
    end
  end

  assign stat = {statB, statA};   // bit 1 is B

  // alarm bank indexes its arrays with this field
  property alarmIdxInRange(alarmCmdT c);
    @(posedge clk_1x) disable iff (reset)
      c.valid |-> (int'(c.alarm) < numAlarms);
  endproperty

  aAlarmIdxA: assert property (alarmIdxInRange(alarmCmdA));
  aAlarmIdxB: assert property (alarmIdxInRange(alarmCmdB));

endmodule

`default_nettype wire

//--- tb.f
ats21Pkg.sv
wordAssembler.sv
commandDecoder.sv
clockBank.sv
alarmBank.sv
ats21Top.sv
tbAts21.sv

//--- tbAts21.sv
/*
  ATS21 testbench
  directed tests for status, conflicts, absolute alarms,
  countdown timers, enable control and repeating alarms
*/
`default_nettype none

module tbAts21 import ats21Pkg::*;;

  localparam int numClocks = 16;
  localparam int numAlarms = 24;
  localparam int timeoutCycles = 4000;  // all tests together run well under 1000 cycles

  logic                 clk_1x;
  logic                 reset;
  logic                 req;
  logic [15:0]          ctrlA;
  logic [15:0]          ctrlB;
  logic [1:0]           stat;
  logic [numAlarms-1:0] data;

  logic [15:0] lfsr;       // galois state
  int          errCount;
  int          testCount;
  int          failedTests;
  int          clockBase, clockUsed;
  int          alarmBase, alarmUsed;

  ats21Top #(
    .numClocks (numClocks),
    .numAlarms (numAlarms)
  ) ats21Top_i (
    .clk_1x (clk_1x),
    .reset  (reset),
    .req    (req),
    .ctrlA  (ctrlA),
    .ctrlB  (ctrlB),
    .stat   (stat),
    .data   (data)
  );

  initial clk_1x = 1'b0;
  always #50 clk_1x = ~clk_1x;    // period 100

  //////////////////////////////
  // random picks and builders
  //////////////////////////////
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  // one step per bit taken
  function automatic logic [15:0] randBits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[14:0], lfsr[0]};
      lfsr = lfsrStep(lfsr);
    end
    return v;
  endfunction

  function automatic logic [3:0] allocClock();
    clockUsed++;
    return 4'((clockBase + clockUsed) % numClocks);
  endfunction

  function automatic logic [4:0] allocAlarm();
    alarmUsed++;
    return 5'((alarmBase + alarmUsed) % numAlarms);
  endfunction

  // upper half {op, target, flag, rate, spare, clock}, lower half value
  function automatic logic [31:0] buildInstr(input logic [2:0] op, input logic [4:0] target,
      input logic flag, input logic [1:0] rate, input logic [3:0] clock,
      input logic [15:0] value);
    return {op, target, flag, rate, 1'b0, clock, value};
  endfunction

  function automatic logic [31:0] setClockInstr(logic [3:0] c, logic [1:0] r, logic [15:0] v);
    return buildInstr(opSetClock, {c, 1'b0}, 1'b0, r, 4'd0, v);  // clock no in target[4:1]
  endfunction

  function automatic logic [31:0] enClockInstr(logic [3:0] c, logic en);
    return buildInstr(opEnClock, {c, 1'b0}, en, 2'd0, 4'd0, 16'd0);
  endfunction

  function automatic logic [31:0] setAlarmInstr(logic [4:0] a, logic [3:0] c, logic rep,
      logic [15:0] v);
    return buildInstr(opSetAlarm, a, rep, 2'd0, c, v);
  endfunction

  function automatic logic [31:0] setTimerInstr(logic [4:0] a, logic [3:0] c, logic [15:0] v);
    return buildInstr(opSetTimer, a, 1'b0, 2'd0, c, v);
  endfunction

  function automatic logic [31:0] enAlarmInstr(logic [4:0] a, logic en);
    return buildInstr(opEnAlarm, a, en, 2'd0, 4'd0, 16'd0);
  endfunction

  //////////////////////////////
  // drive and check helpers
  //////////////////////////////
  task automatic recordError(input string msg);
    $display("%s", msg);
    errCount++;
  endtask

  // both halves for both clients, ends where stat carries the answer
  task automatic sendInstr(input logic [31:0] instrA, input logic [31:0] instrB,
      output logic [1:0] st);
    @(negedge clk_1x);
    req   = 1'b1;
    ctrlA = instrA[31:16];
    ctrlB = instrB[31:16];
    @(negedge clk_1x);
    req   = 1'b0;           // lower half, req not needed
    ctrlA = instrA[15:0];
    ctrlB = instrB[15:0];
    @(negedge clk_1x);
    ctrlA = '0;
    ctrlB = '0;
    @(negedge clk_1x);      // word registered, then decoder answer
    st = stat;
  endtask

  task automatic expectStat(input logic [1:0] got, input logic [1:0] exp, input string what);
    if (got !== exp)
      recordError($sformatf("Fail stat (%s): got %h expected %h", what, got, exp));
  endtask

  task automatic sendExpect(input logic [31:0] instrA, input logic [31:0] instrB,
      input logic [1:0] exp, input string what);
    logic [1:0] st;
    sendInstr(instrA, instrB, st);
    expectStat(st, exp, what);
  endtask

  task automatic expectSilent(input int idx, input int cycles);
    bit seen;
    seen = 1'b0;
    repeat (cycles) begin
      @(negedge clk_1x);
      if (data[idx] !== 1'b0 && !seen) begin
        recordError($sformatf("alarm %0d fired although it should stay silent", idx));
        seen = 1'b1;        // report once
      end
    end
  endtask

  // rise within [lo, hi] cycles, exactly 2 high, then quiet
  task automatic watchAlarm(input int idx, input int lo, input int hi, input int quiet);
    int rise;
    int highLen;
    rise = 0;
    for (int k = 1; k <= hi && rise == 0; k++) begin
      @(negedge clk_1x);
      if (data[idx] === 1'b1) rise = k;
    end
    if (rise == 0) begin
      recordError($sformatf("alarm %0d did not rise within %0d cycles", idx, hi));
      return;
    end
    if (rise < lo)
      recordError($sformatf("alarm %0d rose after %0d cycles, expected %0d to %0d",
                            idx, rise, lo, hi));
    highLen = 1;
    @(negedge clk_1x);
    while (data[idx] === 1'b1 && highLen < 4) begin
      highLen++;
      @(negedge clk_1x);
    end
    if (highLen != 2)
      recordError($sformatf("Fail data[%0d] high cycles: got %h expected %h", idx, highLen, 2));
    expectSilent(idx, quiet);
  endtask

  task automatic closeTest(input string name, input int errsAtStart);
    testCount++;
    if (errCount == errsAtStart) begin
      $display("test %s: ok", name);
    end else begin
      failedTests++;
      $display("test %s: %0d errors", name, errCount - errsAtStart);
    end
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////
  task automatic testResetAndStatus();
    int errs0;
    logic [3:0] c1, c2;
    errs0 = errCount;
    c1 = allocClock();
    c2 = allocClock();
    @(negedge clk_1x);
    if (stat !== 2'b00) recordError($sformatf("Fail stat: got %h expected %h", stat, 2'b00));
    if (data !== '0) recordError($sformatf("Fail data: got %h expected %h", data, 0));
    sendExpect(setClockInstr(c1, 2'd0, randBits(16)), setClockInstr(c2, 2'd1, randBits(16)),
               2'b11, "two set clocks");
    @(negedge clk_1x);                   // answer lasts one cycle
    expectStat(stat, 2'b00, "cycle after answer");
    sendExpect(buildInstr(3'b011, 5'd0, 1'b1, 2'd0, 4'd0, 16'd0),
               buildInstr(3'b100, 5'd0, 1'b0, 2'd0, 4'd0, 16'd0), 2'b00, "opcodes 011 and 100");
    sendExpect(buildInstr(3'b100, 5'd2, 1'b0, 2'd0, 4'd0, 16'd0), enClockInstr(c2, 1'b1),
               2'b10, "only B valid");
    closeTest("reset and status", errs0);
  endtask

  task automatic testConflicts();
    int errs0;
    logic [3:0]  c1, c2;
    logic [4:0]  a, a1, a2;
    logic [15:0] s;
    errs0 = errCount;
    c1 = allocClock();
    c2 = allocClock();
    a  = allocAlarm();
    a1 = allocAlarm();
    a2 = allocAlarm();
    s  = randBits(16);
    sendExpect(setClockInstr(c1, 2'd0, s), setClockInstr(c1, 2'd0, s + 16'd5), 2'b00,
               "same clock");
    sendExpect(setClockInstr(c1, 2'd0, s), setClockInstr(c2, 2'd0, s), 2'b11,
               "different clocks");
    sendExpect(setTimerInstr(a, c1, 16'd8), setAlarmInstr(a, c1, 1'b0, s + 16'd12), 2'b00,
               "same alarm");
    expectSilent(a, 40);                 // neither command reached the alarm
    sendExpect(setTimerInstr(a1, c2, 16'd900), setAlarmInstr(a2, c2, 1'b0, s + 16'd950),
               2'b11, "different alarms");
    closeTest("conflicts", errs0);
  endtask

  task automatic testAbsoluteAlarm();
    int errs0;
    logic [3:0]  c;
    logic [4:0]  a;
    logic [15:0] s;
    int lo[3] = '{10, 16, 36};           // 10 ticks per rate, plus compare latency
    int hi[3] = '{13, 24, 44};
    errs0 = errCount;
    for (int r = 0; r < 3; r++) begin
      c = allocClock();
      a = allocAlarm();
      s = randBits(16);
      sendExpect(setClockInstr(c, 2'(r), s), setAlarmInstr(a, c, 1'b0, s + 16'd10), 2'b11,
                 $sformatf("clock and alarm at rate %0d", r));
      watchAlarm(a, lo[r], hi[r], 30);
    end
    closeTest("absolute alarm", errs0);
  endtask

  task automatic testCountdownTimer();
    int errs0;
    logic [3:0] c;
    logic [4:0] a;
    errs0 = errCount;
    c = allocClock();
    a = allocAlarm();
    sendExpect(setClockInstr(c, 2'd0, randBits(16)), 32'h0, 2'b01, "running clock");
    sendExpect(setTimerInstr(a, c, 16'd12), 32'h0, 2'b01, "timer");
    watchAlarm(a, 12, 15, 20);
    a = allocAlarm();
    sendExpect(setClockInstr(c, 2'd0, 16'hFFF8), 32'h0, 2'b01, "clock near wrap");
    sendExpect(setTimerInstr(a, c, 16'd12), 32'h0, 2'b01, "timer across wrap");
    watchAlarm(a, 12, 15, 20);
    closeTest("countdown timer", errs0);
  endtask

  task automatic testEnableControl();
    int errs0;
    logic [3:0]  c;
    logic [4:0]  a;
    logic [15:0] s;
    errs0 = errCount;
    c = allocClock();
    a = allocAlarm();
    s = randBits(16);
    sendExpect(setClockInstr(c, 2'd0, s), setAlarmInstr(a, c, 1'b0, s + 16'd20), 2'b11, "arm");
    sendExpect(enAlarmInstr(a, 1'b0), 32'h0, 2'b01, "disable alarm");
    expectSilent(a, 30);
    c = allocClock();
    a = allocAlarm();
    s = randBits(16);
    sendExpect(setClockInstr(c, 2'd0, s), setAlarmInstr(a, c, 1'b0, s + 16'd20), 2'b11, "arm");
    sendExpect(enClockInstr(c, 1'b0), 32'h0, 2'b01, "disable clock");
    expectSilent(a, 40);                 // clock parked a few counts past s
    sendExpect(enClockInstr(c, 1'b1), 32'h0, 2'b01, "enable clock");
    watchAlarm(a, 15, 24, 20);
    closeTest("enable control", errs0);
  endtask

  task automatic testRepeat();
    int errs0;
    logic [3:0]  c;
    logic [4:0]  aRep, aOnce;
    logic [15:0] s;
    errs0 = errCount;
    c     = allocClock();
    aRep  = allocAlarm();
    aOnce = allocAlarm();
    s     = randBits(16);
    sendExpect(setAlarmInstr(aOnce, c, 1'b0, s + 16'd10), setAlarmInstr(aRep, c, 1'b1,
               s + 16'd10), 2'b11, "two alarms");
    sendExpect(setClockInstr(c, 2'd0, s), 32'h0, 2'b01, "start clock");
    fork
      watchAlarm(aRep, 10, 13, 5);
      watchAlarm(aOnce, 10, 13, 5);
    join
    sendExpect(setClockInstr(c, 2'd0, s), 32'h0, 2'b01, "reload clock");
    fork
      watchAlarm(aRep, 10, 13, 20);
      expectSilent(aOnce, 35);           // one-shot already disarmed
    join
    closeTest("repeat", errs0);
  endtask

  //////////////////////////////
  // main sequence and watchdog
  //////////////////////////////
  initial begin
    reset       = 1'b1;
    req         = 1'b0;
    ctrlA       = '0;
    ctrlB       = '0;
    lfsr        = 16'd88;
    errCount    = 0;
    testCount   = 0;
    failedTests = 0;
    clockUsed   = 0;
    alarmUsed   = 0;
    clockBase   = int'(randBits(4));
    alarmBase   = int'(randBits(5)) % numAlarms;
    repeat (3) @(posedge clk_1x);
    @(negedge clk_1x);
    reset = 1'b0;
    testResetAndStatus();
    testConflicts();
    testAbsoluteAlarm();
    testCountdownTimer();
    testEnableControl();
    testRepeat();
    $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errCount);
    if (errCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    repeat (timeoutCycles) @(posedge clk_1x);
    $display("timeout, the tests did not finish within %0d cycles", timeoutCycles);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- wordAssembler.sv
/*
  Instruction word assembler
  joins the upper and lower 16-bit halves of one client's
  instruction and pulses a registered 32-bit word
*/
`default_nettype none

module wordAssembler import ats21Pkg::*; (
  input  wire logic        clk_1x,
  input  wire logic        reset,
  input  wire logic        req,
  input  wire logic [15:0] half,
  output cmdWordT          word
);

  typedef enum logic {
    waitUpper,
    waitLower
  } asmStateT;

  asmStateT    state;
  logic        upperOk;     // real upper half on the port
  logic [15:0] upperHalf;   // held until the lower half shows up
  logic        wordValid;
  instrT       wordInstr;

  // nop opcode or missing req means no instruction starts
  assign upperOk = req && (half[15:13] != 3'b000);

  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      state     <= waitUpper;
      wordValid <= 1'b0;
    end else begin
      wordValid <= 1'b0;                    // single-cycle pulse
      case (state)
        waitUpper: if (upperOk) state <= waitLower;
        waitLower: begin
          wordValid <= 1'b1;                // lower taken regardless of req
          state     <= waitUpper;
        end
        default: state <= waitUpper;
      endcase
    end
  end

  // payload path
  always_ff @(posedge clk_1x) begin
    if (state == waitUpper && upperOk) upperHalf <= half;
    if (state == waitLower) wordInstr <= {upperHalf, half};
  end

  assign word = '{valid: wordValid, instr: wordInstr};

endmodule

`default_nettype wire
